// File: logic/lane_check_macros.svh
`ifndef LANE_CHECK_MACROS_SVH
`define LANE_CHECK_MACROS_SVH

// Payload width of one lane
`define LC_DATA_WDTH 6

// Replicated lanes that the comparator chain is written for
`define LC_LANES 4

// Mismatch counter saturating at all ones
`define LC_CNT_WDTH 8

`endif

// File: logic/lane_check_pkg.sv
`default_nettype none

`include "lane_check_macros.svh"

package lane_check_pkg;

   // One lane as delivered by a replica
   typedef struct packed {
      logic                     vld;
      logic [`LC_DATA_WDTH-1:0] data;
   } lane_sample_t;

   typedef lane_sample_t [`LC_LANES-1:0] lane_vec_t;

   typedef logic [`LC_LANES-1:0] lane_mask_t; // One bit per lane

   // Output of the comparator tree
   typedef struct packed {
      logic                     vld;
      logic [`LC_DATA_WDTH-1:0] data;
      logic                     comp_fail;
   } check_result_t;

endpackage

`default_nettype wire

// File: logic/value_comparator.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_check_macros.svh"

module value_comparator (
   input  wire logic                     in_vld0,
   input  wire logic [`LC_DATA_WDTH-1:0] in_data0,
   input  wire logic                     in_vld1,
   input  wire logic [`LC_DATA_WDTH-1:0] in_data1,
   output logic                          out_vld,
   output logic [`LC_DATA_WDTH-1:0]      out_data,
   output logic                          out_comp_fail
);

   always_comb begin
      out_vld       = 1'b0;
      out_data      = in_data0;
      out_comp_fail = 1'b0;
      case ({in_vld1, in_vld0})
         2'b11: begin
            // Both present so input 0 wins and any difference fails
            out_vld       = 1'b1;
            out_data      = in_data0;
            out_comp_fail = (in_data0 != in_data1);
         end
         2'b01: begin
            out_vld  = 1'b1;
            out_data = in_data0;
         end
         2'b10: begin
            out_vld  = 1'b1;
            out_data = in_data1; // Lone valid input passes through
         end
         default: begin
            out_vld  = 1'b0;
            out_data = in_data0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/multiple_value_comparator.sv
`timescale 1ns/1ps
`default_nettype none

module multiple_value_comparator (
   input  wire lane_check_pkg::lane_sample_t in_lane0,
   input  wire lane_check_pkg::lane_sample_t in_lane1,
   input  wire lane_check_pkg::lane_sample_t in_lane2,
   input  wire lane_check_pkg::lane_sample_t in_lane3,
   output lane_check_pkg::check_result_t     result
);

   import lane_check_pkg::*;

   lane_sample_t stage0;
   lane_sample_t stage1;
   lane_sample_t stage2;
   logic [2:0]   stage_fail;

   // Lane 0 against lane 1
   value_comparator u0 (
      .in_vld0       (in_lane0.vld),
      .in_data0      (in_lane0.data),
      .in_vld1       (in_lane1.vld),
      .in_data1      (in_lane1.data),
      .out_vld       (stage0.vld),
      .out_data      (stage0.data),
      .out_comp_fail (stage_fail[0])
   );

   value_comparator u1 (
      .in_vld0       (stage0.vld),
      .in_data0      (stage0.data),
      .in_vld1       (in_lane2.vld),
      .in_data1      (in_lane2.data),
      .out_vld       (stage1.vld),
      .out_data      (stage1.data),
      .out_comp_fail (stage_fail[1])
   );

   value_comparator u2 (
      .in_vld0       (stage1.vld),
      .in_data0      (stage1.data),
      .in_vld1       (in_lane3.vld),
      .in_data1      (in_lane3.data),
      .out_vld       (stage2.vld),
      .out_data      (stage2.data),
      .out_comp_fail (stage_fail[2])
   );

   // Last stage carries the lowest valid lane's data
   assign result.vld       = stage2.vld;
   assign result.data      = stage2.data;
   assign result.comp_fail = |stage_fail;

endmodule

`default_nettype wire

// File: logic/lane_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_check_macros.svh"

module lane_sampler (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire lane_check_pkg::lane_vec_t  lanes,
   input  wire lane_check_pkg::lane_mask_t lane_en,
   output lane_check_pkg::lane_vec_t       sampled
);

   import lane_check_pkg::*;

   lane_mask_t               vld_q;
   logic [`LC_DATA_WDTH-1:0] data_q [`LC_LANES];

   // Strobes gated by the lane enables
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         for (int i = 0; i < `LC_LANES; i++) begin
            vld_q[i] <= lanes[i].vld & lane_en[i];
         end
      end
   end

   // Masked lanes keep their last data
   always_ff @(posedge clk) begin
      for (int i = 0; i < `LC_LANES; i++) begin
         if (lane_en[i]) begin
            data_q[i] <= lanes[i].data;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < `LC_LANES; i++) begin
         sampled[i].vld  = vld_q[i];
         sampled[i].data = data_q[i];
      end
   end

endmodule

`default_nettype wire

// File: logic/mismatch_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_check_macros.svh"

module mismatch_monitor (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire lane_check_pkg::check_result_t cmp,
   input  wire lane_check_pkg::lane_vec_t     sampled,
   input  wire logic                          err_clr,
   output lane_check_pkg::check_result_t      result,
   output logic                               fail_flag,
   output logic [`LC_CNT_WDTH-1:0]            fail_cnt,
   output lane_check_pkg::lane_mask_t         fail_lanes
);

   import lane_check_pkg::*;

   logic                     res_vld_q;
   logic                     res_fail_q;
   logic [`LC_DATA_WDTH-1:0] res_data_q;
   lane_mask_t               diff_lanes;

   // Valid lanes that disagree with the agreed value
   always_comb begin
      for (int i = 0; i < `LC_LANES; i++) begin
         diff_lanes[i] = sampled[i].vld && (sampled[i].data != cmp.data);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_vld_q  <= 1'b0;
         res_fail_q <= 1'b0;
      end else begin
         res_vld_q  <= cmp.vld;
         res_fail_q <= cmp.comp_fail;
      end
   end

   always_ff @(posedge clk) begin
      res_data_q <= cmp.data;
   end

   assign result.vld       = res_vld_q;
   assign result.data      = res_data_q;
   assign result.comp_fail = res_fail_q;

   // Sticky status where a clear wins over a coincident failure
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fail_flag  <= 1'b0;
         fail_cnt   <= '0;
         fail_lanes <= '0;
      end else if (err_clr) begin
         fail_flag  <= 1'b0;
         fail_cnt   <= '0;
         fail_lanes <= '0;
      end else if (cmp.comp_fail) begin
         fail_flag <= 1'b1;
         if (fail_cnt != '1) begin
            fail_cnt <= fail_cnt + 1'b1; // Saturates
         end
         if (!fail_flag) begin
            fail_lanes <= diff_lanes; // First failure only
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/lane_check_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_check_macros.svh"

module lane_check_top (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire lane_check_pkg::lane_vec_t  lanes,
   input  wire lane_check_pkg::lane_mask_t lane_en,
   input  wire logic                       err_clr,
   output lane_check_pkg::check_result_t   result,
   output logic                            fail_flag,
   output logic [`LC_CNT_WDTH-1:0]         fail_cnt,
   output lane_check_pkg::lane_mask_t      fail_lanes
);

   import lane_check_pkg::*;

   lane_vec_t     sampled;
   check_result_t cmp;

   // Input register with lane masking
   lane_sampler lane_sampler_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .lanes   (lanes),
      .lane_en (lane_en),
      .sampled (sampled)
   );

   multiple_value_comparator multiple_value_comparator_i (
      .in_lane0 (sampled[0]),
      .in_lane1 (sampled[1]),
      .in_lane2 (sampled[2]),
      .in_lane3 (sampled[3]),
      .result   (cmp)
   );

   // Result register and error status
   mismatch_monitor mismatch_monitor_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmp        (cmp),
      .sampled    (sampled),
      .err_clr    (err_clr),
      .result     (result),
      .fail_flag  (fail_flag),
      .fail_cnt   (fail_cnt),
      .fail_lanes (fail_lanes)
   );

endmodule

`default_nettype wire

// File: test/lane_check_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_check_macros.svh"

module lane_check_tb;

   import lane_check_pkg::*;

   localparam int RESET_CYCLES = 5;
   localparam int N_AGREE      = 200;
   localparam int N_MASKED     = 200;
   localparam int N_BURST      = 300;
   localparam int N_RECOVER    = 40;
   localparam int N_DRAIN      = 4;
   localparam int STIM_CYCLES  = RESET_CYCLES + 1 + N_AGREE + N_MASKED + N_BURST
                                 + N_RECOVER + N_DRAIN;
   localparam int CYCLE_LIMIT  = STIM_CYCLES + 20;

   localparam int MODE_AGREE  = 0;
   localparam int MODE_MASKED = 1;
   localparam int MODE_BURST  = 2; // Every lane independent

   logic                    clk;
   logic                    rst_n;
   lane_vec_t               lanes;
   lane_mask_t              lane_en;
   logic                    err_clr;
   check_result_t           result;
   logic                    fail_flag;
   logic [`LC_CNT_WDTH-1:0] fail_cnt;
   lane_mask_t              fail_lanes;

   logic [15:0]             lfsr = 16'd11445;
   int                      cycle_cnt = 0;

   check_result_t           res_q[$]; // Predictions still in the pipeline
   lane_mask_t              diff_q[$];
   logic                    clr_prev; // Clear seen by the status registers next edge
   logic                    exp_flag;
   logic [`LC_CNT_WDTH-1:0] exp_cnt;
   lane_mask_t              exp_lanes;

   lane_check_top lane_check_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .lanes      (lanes),
      .lane_en    (lane_en),
      .err_clr    (err_clr),
      .result     (result),
      .fail_flag  (fail_flag),
      .fail_cnt   (fail_cnt),
      .fail_lanes (fail_lanes)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopped at first error");
   endtask

   // Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic make_vector(input int mode, output lane_vec_t v, output lane_mask_t en);
      logic [`LC_DATA_WDTH-1:0] common;
      common = `LC_DATA_WDTH'(rand_bits(`LC_DATA_WDTH));
      en     = (mode == MODE_MASKED) ? lane_mask_t'(rand_bits(`LC_LANES)) : '1;
      for (int i = 0; i < `LC_LANES; i++) begin
         v[i].vld  = 1'b1;
         v[i].data = common;
         // Roughly one lane in eight diverges and masked lanes always do
         if (rand_bits(3) == 0 || mode == MODE_BURST || !en[i]) begin
            v[i].data = `LC_DATA_WDTH'(rand_bits(`LC_DATA_WDTH));
         end
         if (mode == MODE_MASKED && rand_bits(2) == 0) begin
            v[i].vld = 1'b0;
         end
      end
   endtask

   // Agreed value comes from the lowest live lane and any other live lane that differs fails
   task automatic predict(input lane_vec_t v, input lane_mask_t en,
                          output check_result_t r, output lane_mask_t diff);
      lane_mask_t live;
      r = '0;
      for (int i = 0; i < `LC_LANES; i++) begin
         live[i] = v[i].vld & en[i];
      end
      for (int i = `LC_LANES - 1; i >= 0; i--) begin
         if (live[i]) begin
            r.vld  = 1'b1;
            r.data = v[i].data;
         end
      end
      for (int i = 0; i < `LC_LANES; i++) begin
         diff[i] = live[i] && (v[i].data != r.data);
      end
      r.comp_fail = |diff;
   endtask

   task automatic check_result(input check_result_t exp, input check_result_t act);
      if (act.vld !== exp.vld) begin
         $display("** Error: result.vld expected %h got %h", exp.vld, act.vld);
         abort_run();
      end else if (act.comp_fail !== exp.comp_fail) begin
         $display("** Error: result.comp_fail expected %h got %h", exp.comp_fail,
                  act.comp_fail);
         abort_run();
      end else if (exp.vld && act.data !== exp.data) begin
         $display("** Error: result.data expected %h got %h", exp.data, act.data);
         abort_run();
      end
   endtask

   task automatic check_status(input logic exp_f, input logic act_f,
                               input logic [`LC_CNT_WDTH-1:0] exp_c,
                               input logic [`LC_CNT_WDTH-1:0] act_c,
                               input lane_mask_t exp_l, input lane_mask_t act_l);
      if (act_f !== exp_f) begin
         $display("** Error: fail_flag expected %h got %h", exp_f, act_f);
         abort_run();
      end else if (act_c !== exp_c) begin
         $display("** Error: fail_cnt expected %h got %h", exp_c, act_c);
         abort_run();
      end else if (act_l !== exp_l) begin
         $display("** Error: fail_lanes expected %h got %h", exp_l, act_l);
         abort_run();
      end
   endtask

   // Drive one vector and check the one that entered the pipeline two calls earlier
   task automatic run_cycle(input lane_vec_t v, input lane_mask_t en, input logic clr);
      check_result_t exp_res;
      lane_mask_t    exp_diff;
      check_result_t new_res;
      lane_mask_t    new_diff;
      @(posedge clk);
      lanes   <= v;
      lane_en <= en;
      err_clr <= clr;
      predict(v, en, new_res, new_diff);
      @(negedge clk);
      exp_res  = res_q.pop_front();
      exp_diff = diff_q.pop_front();
      if (clr_prev) begin
         exp_flag  = 1'b0;
         exp_cnt   = '0;
         exp_lanes = '0;
      end else if (exp_res.comp_fail) begin
         if (!exp_flag) begin
            exp_lanes = exp_diff;
         end
         exp_flag = 1'b1;
         if (exp_cnt != '1) begin
            exp_cnt = exp_cnt + 1'b1;
         end
      end
      clr_prev = clr;
      check_result(exp_res, result);
      check_status(exp_flag, fail_flag, exp_cnt, fail_cnt, exp_lanes, fail_lanes);
      res_q.push_back(new_res);
      diff_q.push_back(new_diff);
   endtask

   initial begin
      lane_vec_t  vec;
      lane_mask_t en;
      rst_n     = 1'b0;
      lanes     = '0;
      lane_en   = '0;
      err_clr   = 1'b0;
      clr_prev  = 1'b0;
      exp_flag  = 1'b0;
      exp_cnt   = '0;
      exp_lanes = '0;
      repeat (2) begin
         res_q.push_back('0); // Both stages empty out of reset
         diff_q.push_back('0);
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_result('0, result);
      check_status(1'b0, fail_flag, '0, fail_cnt, '0, fail_lanes);

      for (int i = 0; i < N_AGREE; i++) begin
         make_vector(MODE_AGREE, vec, en);
         run_cycle(vec, en, 1'b0);
      end
      for (int i = 0; i < N_MASKED; i++) begin
         make_vector(MODE_MASKED, vec, en);
         run_cycle(vec, en, rand_bits(5) == 0);
      end
      for (int i = 0; i < N_BURST; i++) begin
         make_vector(MODE_BURST, vec, en);
         run_cycle(vec, en, 1'b0);
      end
      if (exp_cnt != '1) begin
         $display("The corrupted burst did not bring the mismatch counter to saturation");
         abort_run();
      end
      // Clear lands on a failing result and status counts up again from zero
      for (int i = 0; i < N_RECOVER; i++) begin
         make_vector(MODE_BURST, vec, en);
         run_cycle(vec, en, i == 10);
      end
      for (int i = 0; i < N_DRAIN; i++) begin
         run_cycle('0, '1, 1'b0);
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: lane_check_top.f
+incdir+logic
logic/lane_check_pkg.sv
logic/value_comparator.sv
logic/multiple_value_comparator.sv
logic/lane_sampler.sv
logic/mismatch_monitor.sv
logic/lane_check_top.sv
test/lane_check_tb.sv

// File: Bender.yml
package:
  name: lane_check

sources:
  - include_dirs:
      - logic
    files:
      - logic/lane_check_pkg.sv
      - logic/value_comparator.sv
      - logic/multiple_value_comparator.sv
      - logic/lane_sampler.sv
      - logic/mismatch_monitor.sv
      - logic/lane_check_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/lane_check_tb.sv
